//--- hw/pmp_settings.svh
// PMP build settings shared by the package and the RTL
// Address width is fixed at 34 bits, pmpaddr holds bits 33:2
`ifndef PMP_SETTINGS_SVH
`define PMP_SETTINGS_SVH

// Number of implemented PMP entries, a multiple of four
`define PMP_NUM_REGIONS 8

// NAPOT granule as an exponent, 0 gives 4 byte granules
`define PMP_GRANULARITY 0

// Physical address width in bits
`define PMP_ADDR_W 34

// Width of the CSR select on the write and readback port
`define PMP_CSR_SEL_W 5

`endif

//--- hw/pmp_pkg.sv
// Shared PMP types and CSR select codes
// Entry count and widths come from the settings header
`include "pmp_settings.svh"

package pmp_pkg;

  // ------------------------------
  // Encodings
  // ------------------------------

  // Address matching mode in the A field
  typedef enum logic [1:0] {
    PMP_MODE_OFF   = 2'b00,
    PMP_MODE_TOR   = 2'b01,
    PMP_MODE_NA4   = 2'b10,
    PMP_MODE_NAPOT = 2'b11
  } pmp_mode_e;

  // Kind of access being checked
  typedef enum logic [1:0] {
    PMP_ACC_READ  = 2'b00,
    PMP_ACC_WRITE = 2'b01,
    PMP_ACC_EXEC  = 2'b10
  } pmp_acc_e;

  // Privilege level, same codes as mstatus.MPP
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_S = 2'b01,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // ------------------------------
  // CSR layout
  // ------------------------------

  // One pmpcfg byte, bit 7 down to bit 0
  typedef struct packed {
    logic      lock;
    logic [1:0] reserved;
    pmp_mode_e mode;
    logic      exec;
    logic      write;
    logic      read;
  } pmp_cfg_t;

  // A pmpcfg CSR word seen whole or as four entry bytes
  typedef union packed {
    logic [31:0]       raw;
    pmp_cfg_t [3:0]    cfg;
  } pmp_cfg_word_u;

  // mseccfg bits 2:0
  typedef struct packed {
    logic rlb;
    logic mmwp;
    logic mml;
  } mseccfg_t;

  // Full register state handed to the checker
  typedef struct packed {
    pmp_cfg_t [`PMP_NUM_REGIONS-1:0]                  cfg;
    logic [`PMP_NUM_REGIONS-1:0][`PMP_ADDR_W-1:0]     addr;
    mseccfg_t                                         mseccfg;
  } pmp_csr_t;

  // ------------------------------
  // Request and response
  // ------------------------------

  typedef logic [$clog2(`PMP_NUM_REGIONS)-1:0] pmp_idx_t;

  typedef struct packed {
    logic [`PMP_ADDR_W-1:0] addr;
    pmp_acc_e               acc;
    priv_lvl_e              priv;
  } pmp_req_t;

  // Index is 0 when no entry matched
  typedef struct packed {
    logic     err;
    pmp_idx_t idx;
  } pmp_resp_t;

  // CSR select codes, also used by the bench
  typedef logic [`PMP_CSR_SEL_W-1:0] csr_sel_t;

  localparam csr_sel_t CSR_PMPCFG0  = 0;
  localparam csr_sel_t CSR_PMPCFG1  = 1;
  localparam csr_sel_t CSR_PMPADDR0 = 8;
  localparam csr_sel_t CSR_MSECCFG  = 16;

endpackage

//--- hw/pmp_csr_regs.sv
// PMP and mseccfg CSRs with lock, TOR neighbour lock, rlb and sticky bit rules
// Only full-word pmpcfg writes, no WARL legalisation beyond locking
`timescale 1ns/1ps
`include "pmp_settings.svh"

module pmp_csr_regs (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                csr_we_i,
  input  pmp_pkg::csr_sel_t   csr_sel_i,
  input  logic [31:0]         csr_wdata_i,
  output logic [31:0]         csr_rdata_o,
  output pmp_pkg::pmp_csr_t   csr_pmp_o
);
  import pmp_pkg::*;

  pmp_csr_t                    csr_q;
  pmp_csr_t                    csr_d;
  pmp_cfg_word_u               wr_word;
  pmp_cfg_word_u               rd_word;
  logic [`PMP_NUM_REGIONS-1:0] cfg_wr_ok;
  logic [`PMP_NUM_REGIONS-1:0] addr_wr_ok;
  logic                        any_lock;

  // ------------------------------
  // Write permission per entry
  // ------------------------------

  // Any locked entry keeps rlb from being set
  always_comb begin
    any_lock = 1'b0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      any_lock = any_lock | csr_q.cfg[i].lock;
    end
  end

  for (genvar i = 0; i < `PMP_NUM_REGIONS; i++) begin : g_lock
    // Own lock, bypassed by rlb
    assign cfg_wr_ok[i] = !csr_q.cfg[i].lock || csr_q.mseccfg.rlb;
    if (i == `PMP_NUM_REGIONS - 1) begin : g_last
      assign addr_wr_ok[i] = cfg_wr_ok[i];
    end else begin : g_mid
      // Next entry locked as TOR also freezes this address
      assign addr_wr_ok[i] = cfg_wr_ok[i] &&
                             (!(csr_q.cfg[i+1].lock && csr_q.cfg[i+1].mode == PMP_MODE_TOR) ||
                              csr_q.mseccfg.rlb);
    end
  end

  // ------------------------------
  // Next state
  // ------------------------------

  assign wr_word.raw = csr_wdata_i;

  always_comb begin
    csr_d = csr_q;
    if (csr_we_i) begin
      for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
        // Byte i%4 of pmpcfg word i/4
        if (csr_sel_i == CSR_PMPCFG0 + csr_sel_t'(i / 4) && cfg_wr_ok[i]) begin
          csr_d.cfg[i] = wr_word.cfg[i % 4];
        end
        if (csr_sel_i == CSR_PMPADDR0 + csr_sel_t'(i) && addr_wr_ok[i]) begin
          csr_d.addr[i] = {csr_wdata_i, 2'b00};
        end
      end
      if (csr_sel_i == CSR_MSECCFG) begin
        // mml and mmwp only clear on reset
        csr_d.mseccfg.mml  = csr_q.mseccfg.mml | csr_wdata_i[0];
        csr_d.mseccfg.mmwp = csr_q.mseccfg.mmwp | csr_wdata_i[1];
        // rlb sets only with no lock, may always clear
        csr_d.mseccfg.rlb  = csr_wdata_i[2] && (csr_q.mseccfg.rlb || !any_lock);
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      csr_q <= '0;
    end else begin
      csr_q <= csr_d;
    end
  end

  assign csr_pmp_o = csr_q;

  // ------------------------------
  // Readback
  // ------------------------------

  always_comb begin
    rd_word.raw = '0;
    csr_rdata_o = '0;
    for (int i = 0; i < `PMP_NUM_REGIONS; i++) begin
      if (csr_sel_i == CSR_PMPCFG0 + csr_sel_t'(i / 4)) begin
        rd_word.cfg[i % 4] = csr_q.cfg[i];
      end
      if (csr_sel_i == CSR_PMPADDR0 + csr_sel_t'(i)) begin
        csr_rdata_o = csr_q.addr[i][`PMP_ADDR_W-1:2];
      end
    end
    if (csr_sel_i == CSR_PMPCFG0 || csr_sel_i == CSR_PMPCFG1) begin
      csr_rdata_o = rd_word.raw;
    end
    if (csr_sel_i == CSR_MSECCFG) begin
      csr_rdata_o = {29'b0, csr_q.mseccfg};
    end
  end

endmodule

//--- hw/pmp_region_match.sv
// Per-entry address match for TOR, NA4 and NAPOT, purely combinational
// Compares only address bits at or above the configured granule
`timescale 1ns/1ps
`include "pmp_settings.svh"

module pmp_region_match (
  input  pmp_pkg::pmp_csr_t             csr_pmp_i,
  input  logic [`PMP_ADDR_W-1:0]        req_addr_i,
  output logic [`PMP_NUM_REGIONS-1:0]   match_o
);
  import pmp_pkg::*;

  // Lowest compared address bit
  localparam int LSB = `PMP_GRANULARITY + 2;
  // Lowest pmpaddr bit that takes part in the NAPOT size
  localparam int ONES_LO = (`PMP_GRANULARITY == 0) ? 2 : `PMP_GRANULARITY + 1;

  logic [`PMP_NUM_REGIONS-1:0][`PMP_ADDR_W-1:0]   start_addr;
  logic [`PMP_NUM_REGIONS-1:0][`PMP_ADDR_W-1:LSB] addr_mask;
  logic [`PMP_NUM_REGIONS-1:0]                    match_eq;
  logic [`PMP_NUM_REGIONS-1:0]                    match_ge;
  logic [`PMP_NUM_REGIONS-1:0]                    match_lt;

  for (genvar i = 0; i < `PMP_NUM_REGIONS; i++) begin : g_entry

    // ------------------------------
    // Region base
    // ------------------------------

    // TOR starts at the previous entry, entry 0 at address 0
    if (i == 0) begin : g_first
      assign start_addr[i] = (csr_pmp_i.cfg[i].mode == PMP_MODE_TOR) ? '0 :
                             csr_pmp_i.addr[i];
    end else begin : g_rest
      assign start_addr[i] = (csr_pmp_i.cfg[i].mode == PMP_MODE_TOR) ? csr_pmp_i.addr[i-1] :
                             csr_pmp_i.addr[i];
    end

    // ------------------------------
    // NAPOT mask
    // ------------------------------

    // A bit is masked when all pmpaddr bits below it are ones
    for (genvar b = LSB; b < `PMP_ADDR_W; b++) begin : g_bit
      if (`PMP_GRANULARITY == 0 && b == 2) begin : g_bottom
        // Smallest NAPOT is 8 bytes so bit 2 never compares
        assign addr_mask[i][b] = (csr_pmp_i.cfg[i].mode != PMP_MODE_NAPOT);
      end else begin : g_upper
        assign addr_mask[i][b] = (csr_pmp_i.cfg[i].mode != PMP_MODE_NAPOT) ||
                                 !(&csr_pmp_i.addr[i][b-1:ONES_LO]);
      end
    end

    // ------------------------------
    // Comparators
    // ------------------------------

    assign match_eq[i] = (req_addr_i[`PMP_ADDR_W-1:LSB] & addr_mask[i]) ==
                         (start_addr[i][`PMP_ADDR_W-1:LSB] & addr_mask[i]);
    assign match_ge[i] = req_addr_i[`PMP_ADDR_W-1:LSB] >= start_addr[i][`PMP_ADDR_W-1:LSB];
    // Top of a TOR region is exclusive
    assign match_lt[i] = req_addr_i[`PMP_ADDR_W-1:LSB] < csr_pmp_i.addr[i][`PMP_ADDR_W-1:LSB];

    always_comb begin
      case (csr_pmp_i.cfg[i].mode)
        PMP_MODE_TOR:   match_o[i] = match_ge[i] && match_lt[i];
        PMP_MODE_NA4:   match_o[i] = match_eq[i];
        PMP_MODE_NAPOT: match_o[i] = match_eq[i];
        default:        match_o[i] = 1'b0;
      endcase
    end

  end

endmodule

//--- hw/pmp_perm_check.sv
// Per-entry fault decision, classic rules or Smepmp MML rules
// Result is meaningful only for entries that match the address
`timescale 1ns/1ps
`include "pmp_settings.svh"

module pmp_perm_check (
  input  pmp_pkg::pmp_csr_t             csr_pmp_i,
  input  pmp_pkg::pmp_acc_e             req_type_i,
  input  pmp_pkg::priv_lvl_e            priv_lvl_i,
  output logic [`PMP_NUM_REGIONS-1:0]   fault_o
);
  import pmp_pkg::*;

  logic                        is_read;
  logic                        is_write;
  logic                        is_exec;
  logic                        is_m;
  logic [`PMP_NUM_REGIONS-1:0] basic_ok;
  logic [`PMP_NUM_REGIONS-1:0] mml_ok;

  // Decoded request
  assign is_read  = (req_type_i == PMP_ACC_READ);
  assign is_write = (req_type_i == PMP_ACC_WRITE);
  assign is_exec  = (req_type_i == PMP_ACC_EXEC);
  assign is_m     = (priv_lvl_i == PRIV_LVL_M);

  for (genvar i = 0; i < `PMP_NUM_REGIONS; i++) begin : g_entry
    pmp_cfg_t cfg;

    assign cfg = csr_pmp_i.cfg[i];

    // Access type has its R, W or X bit
    assign basic_ok[i] = (is_read && cfg.read) || (is_write && cfg.write) ||
                         (is_exec && cfg.exec);

    // ------------------------------
    // MML permissions
    // ------------------------------

    always_comb begin
      if (!cfg.read && cfg.write) begin
        // Shared regions, decoded by lock and exec
        case ({cfg.lock, cfg.exec})
          // RW in M, read only in S/U
          2'b00:   mml_ok[i] = is_read || (is_write && is_m);
          // RW everywhere
          2'b01:   mml_ok[i] = is_read || is_write;
          // Exec only everywhere
          2'b10:   mml_ok[i] = is_exec;
          // RX in M, exec only in S/U
          default: mml_ok[i] = is_exec || (is_read && is_m);
        endcase
      end else if (cfg.lock && cfg.read && cfg.write && cfg.exec) begin
        // Locked RWX becomes a shared read-only region
        mml_ok[i] = is_read;
      end else if (is_m) begin
        // M mode needs a locked rule
        mml_ok[i] = cfg.lock && basic_ok[i];
      end else begin
        // S/U mode needs an unlocked rule
        mml_ok[i] = !cfg.lock && basic_ok[i];
      end
    end

    // ------------------------------
    // Fault per entry
    // ------------------------------

    always_comb begin
      if (csr_pmp_i.mseccfg.mml) begin
        fault_o[i] = !mml_ok[i];
      end else if (is_m) begin
        // Unlocked entries do not restrict M mode
        fault_o[i] = cfg.lock && !basic_ok[i];
      end else begin
        fault_o[i] = !basic_ok[i];
      end
    end
  end

endmodule

//--- hw/pmp_fault_resolve.sv
// Priority pick of the lowest matching entry, one cycle response
// No back-pressure, a new request may enter every cycle
`timescale 1ns/1ps
`include "pmp_settings.svh"

module pmp_fault_resolve (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic                          req_valid_i,
  input  pmp_pkg::priv_lvl_e            priv_lvl_i,
  input  pmp_pkg::mseccfg_t             mseccfg_i,
  input  logic [`PMP_NUM_REGIONS-1:0]   match_i,
  input  logic [`PMP_NUM_REGIONS-1:0]   fault_i,
  output logic                          resp_valid_o,
  output pmp_pkg::pmp_resp_t            resp_o
);
  import pmp_pkg::*;

  pmp_resp_t resp_d;

  // Default rule, then entries from high to low so entry 0 wins
  always_comb begin
    resp_d.err = mseccfg_i.mmwp || (priv_lvl_i != PRIV_LVL_M);
    resp_d.idx = '0;
    for (int i = `PMP_NUM_REGIONS - 1; i >= 0; i--) begin
      if (match_i[i]) begin
        resp_d.err = fault_i[i];
        resp_d.idx = pmp_idx_t'(i);
      end
    end
  end

  // ------------------------------
  // Response register
  // ------------------------------

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_o <= 1'b0;
    end else begin
      resp_valid_o <= req_valid_i;
    end
  end

  // Payload only loads with a request
  always_ff @(posedge clk_i) begin
    if (req_valid_i) begin
      resp_o <= resp_d;
    end
  end

endmodule

//--- hw/pmp_top.sv
// PMP checker top, CSR port plus one-cycle request pipeline
// CSR writes land next cycle, a same-cycle request sees old values
`timescale 1ns/1ps
`include "pmp_settings.svh"

module pmp_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                csr_we_i,
  input  pmp_pkg::csr_sel_t   csr_sel_i,
  input  logic [31:0]         csr_wdata_i,
  output logic [31:0]         csr_rdata_o,
  input  logic                req_valid_i,
  input  pmp_pkg::pmp_req_t   req_i,
  output logic                resp_valid_o,
  output pmp_pkg::pmp_resp_t  resp_o
);
  import pmp_pkg::*;

  pmp_csr_t                    csr_pmp;
  logic [`PMP_NUM_REGIONS-1:0] match;
  logic [`PMP_NUM_REGIONS-1:0] fault;

  // ------------------------------
  // Register file
  // ------------------------------

  pmp_csr_regs pmp_csr_regs_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .csr_we_i    (csr_we_i),
    .csr_sel_i   (csr_sel_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .csr_pmp_o   (csr_pmp)
  );

  // ------------------------------
  // Check datapath
  // ------------------------------

  // Matcher and checker run side by side on the same request
  pmp_region_match pmp_region_match_inst (
    .csr_pmp_i  (csr_pmp),
    .req_addr_i (req_i.addr),
    .match_o    (match)
  );

  pmp_perm_check pmp_perm_check_inst (
    .csr_pmp_i  (csr_pmp),
    .req_type_i (req_i.acc),
    .priv_lvl_i (req_i.priv),
    .fault_o    (fault)
  );

  pmp_fault_resolve pmp_fault_resolve_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .priv_lvl_i   (req_i.priv),
    .mseccfg_i    (csr_pmp.mseccfg),
    .match_i      (match),
    .fault_i      (fault),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

endmodule

//--- bench/pmp_tb.sv
// Stimulus-file driven testbench for the PMP checker, stops at the first mismatch
// Run from the project root so the relative path of the data file resolves
`timescale 1ns/1ps
`include "pmp_settings.svh"

module pmp_tb;
  import pmp_pkg::*;

  // Cycles to wait for a response before giving up
  localparam int RESP_TIMEOUT = 20;

  logic                   clk_i;
  logic                   rst_n_i;
  logic                   csr_we_i;
  csr_sel_t               csr_sel_i;
  logic [31:0]            csr_wdata_i;
  logic [31:0]            csr_rdata_o;
  logic                   req_valid_i;
  pmp_req_t               req_i;
  logic                   resp_valid_o;
  pmp_resp_t              resp_o;

  // Requests held back for one back-to-back burst
  string                  burst_name_q[$];
  pmp_req_t               burst_req_q[$];
  pmp_resp_t              burst_exp_q[$];

  pmp_top pmp_top_inst (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .csr_we_i     (csr_we_i),
    .csr_sel_i    (csr_sel_i),
    .csr_wdata_i  (csr_wdata_i),
    .csr_rdata_o  (csr_rdata_o),
    .req_valid_i  (req_valid_i),
    .req_i        (req_i),
    .resp_valid_o (resp_valid_o),
    .resp_o       (resp_o)
  );

  // 40 ns period
  always #20 clk_i = ~clk_i;

  // ------------------------------
  // Helpers
  // ------------------------------

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_val(input string name, input logic [63:0] exp_val,
                           input logic [63:0] act_val);
    if (act_val !== exp_val) begin
      abort_run($sformatf("ERROR %s expected %0h actual %0h", name, exp_val, act_val));
    end
  endtask

  task automatic need_fields(input int got, input int want, input string op);
    if (got != want) begin
      abort_run($sformatf("Stimulus line %s has %0d fields, needs %0d", op, got, want));
    end
  endtask

  // Inputs change 2 ns after the rising edge, outputs are sampled there too
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic apply_reset();
    rst_n_i     = 1'b0;
    csr_we_i    = 1'b0;
    csr_sel_i   = '0;
    csr_wdata_i = '0;
    req_valid_i = 1'b0;
    req_i       = '0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    check_val("reset_resp_valid", 64'd0, resp_valid_o);
  endtask

  // ------------------------------
  // CSR port
  // ------------------------------

  task automatic csr_write(input csr_sel_t sel, input logic [31:0] data);
    csr_we_i    = 1'b1;
    csr_sel_i   = sel;
    csr_wdata_i = data;
    next_cycle();
    csr_we_i    = 1'b0;
  endtask

  // Readback is combinational, sampled one cycle after the select settles
  task automatic csr_read_check(input csr_sel_t sel, input logic [31:0] exp_val);
    csr_sel_i = sel;
    next_cycle();
    check_val($sformatf("readback_sel_%0h", sel), exp_val, csr_rdata_o);
  endtask

  // ------------------------------
  // Request port
  // ------------------------------

  task automatic single_request(input string name, input pmp_req_t req,
                                input pmp_resp_t exp_resp);
    int waited;
    waited      = 0;
    req_valid_i = 1'b1;
    req_i       = req;
    do begin
      next_cycle();
      req_valid_i = 1'b0;
      waited++;
    end while (!resp_valid_o && waited < RESP_TIMEOUT);
    if (!resp_valid_o) begin
      abort_run($sformatf("No response to request %s within %0d cycles", name, RESP_TIMEOUT));
    end
    check_val({name, "_err"}, exp_resp.err, resp_o.err);
    check_val({name, "_idx"}, exp_resp.idx, resp_o.idx);
  endtask

  // One request per cycle, each response due exactly one cycle later
  task automatic run_burst();
    string     name;
    pmp_resp_t exp_resp;
    while (burst_req_q.size() > 0) begin
      req_valid_i = 1'b1;
      req_i       = burst_req_q.pop_front();
      name        = burst_name_q.pop_front();
      exp_resp    = burst_exp_q.pop_front();
      next_cycle();
      check_val({name, "_valid"}, 64'd1, resp_valid_o);
      check_val({name, "_err"}, exp_resp.err, resp_o.err);
      check_val({name, "_idx"}, exp_resp.idx, resp_o.idx);
    end
    req_valid_i = 1'b0;
    next_cycle();
    // No extra response after the burst
    check_val("burst_drain_valid", 64'd0, resp_valid_o);
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------

  initial begin : main_seq
    int                     fd;
    int                     n;
    string                  op;
    string                  name;
    string                  line;
    csr_sel_t               sel;
    logic [31:0]            data;
    logic [1:0]             priv;
    logic [1:0]             acc;
    logic [`PMP_ADDR_W-1:0] addr;
    logic                   err;
    pmp_idx_t               idx;
    pmp_req_t               req;
    pmp_resp_t              exp_resp;

    clk_i = 1'b0;
    apply_reset();

    fd = $fopen("bench/pmp_stimulus.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open bench/pmp_stimulus.txt");
    end

    while (!$feof(fd)) begin
      n = $fscanf(fd, "%s", op);
      if (n != 1) begin
        // Only whitespace left
        break;
      end
      if (op[0] == "#") begin
        n = $fgets(line, fd);
      end else if (op == "W") begin
        n = $fscanf(fd, "%h %h", sel, data);
        need_fields(n, 2, op);
        csr_write(sel, data);
      end else if (op == "R") begin
        n = $fscanf(fd, "%h %h", sel, data);
        need_fields(n, 2, op);
        csr_read_check(sel, data);
      end else if (op == "C" || op == "P") begin
        n = $fscanf(fd, "%s %h %h %h %h %h", name, priv, acc, addr, err, idx);
        need_fields(n, 6, op);
        req.addr      = addr;
        req.acc       = pmp_acc_e'(acc);
        req.priv      = priv_lvl_e'(priv);
        exp_resp.err  = err;
        exp_resp.idx  = idx;
        if (op == "C") begin
          single_request(name, req, exp_resp);
        end else begin
          burst_name_q.push_back(name);
          burst_req_q.push_back(req);
          burst_exp_q.push_back(exp_resp);
        end
      end else if (op == "G") begin
        run_burst();
      end else if (op == "X") begin
        apply_reset();
      end else begin
        abort_run($sformatf("Unknown stimulus operation %s", op));
      end
    end
    $fclose(fd);

    $display("sim passed");
    $finish;
  end

endmodule

//--- bench/pmp_stimulus.txt
# W sel data | R sel expected | C/P name priv type addr err idx | G runs P burst | X reset
# All numbers hex; priv U=0 S=1 M=3; type read=0 write=1 exec=2
# Classic layout: TOR 0x1000-0x1FFF RW, NA4 0x3000 RX, NAPOT 0x4000 4K R, NAPOT 0x4000 8K RWX
W 08 00000400
W 09 00000800
W 0a 00000c00
W 0b 000011ff
W 0c 000013ff
W 00 19150b00
W 01 0000001f
# Region edges in U mode
C tor_below 0 0 0ffc 1 0
C tor_low 0 0 1000 0 1
C tor_top_wr 0 1 1ffc 0 1
C tor_above 0 0 2000 1 0
C tor_exec 0 2 1000 1 1
C na4_rd 0 0 3000 0 2
C na4_ex 0 2 3000 0 2
C na4_wr 0 1 3000 1 2
C na4_after 0 0 3004 1 0
C napot_low 0 0 4000 0 3
C napot_top 0 0 4ffc 0 3
C napot_below 0 0 3ffc 1 0
# Overlap resolves to the lower entry
C prio_wr 0 1 4800 1 3
C big_wr 0 1 5000 0 4
C big_above 0 1 6000 1 0
C s_mode_rd 1 0 1000 0 1
# M mode ignores unlocked entries, default passes
C m_unlocked 3 1 4800 0 3
C m_nomatch 3 0 8000 0 0
# Lock entry 3
W 00 99150b00
C m_locked_wr 3 1 4800 1 3
C m_locked_rd 3 0 4800 0 3
W 00 00150b00
R 00 99150b00
W 0b 00000000
R 0b 000011ff
# Lock TOR entry 1, pmpaddr0 and pmpaddr1 freeze
W 00 99158b00
R 00 99158b00
W 08 00000123
R 08 00000400
W 09 00000000
R 09 00000800
# rlb refused while locked, mmwp sticky
W 10 00000004
R 10 00000000
W 10 00000002
C mmwp_m_nomatch 3 0 8000 1 0
W 10 00000000
R 10 00000002
X
R 00 00000000
R 10 00000000
# rlb set before any lock
W 10 00000004
R 10 00000004
W 08 00000400
W 00 00000091
R 00 00000091
W 08 00000500
R 08 00000500
W 00 00000000
R 00 00000000
# MML layout: NA4 entries at 0x1000 + 0x100 * index
W 08 00000400
W 09 00000440
W 0a 00000480
W 0b 000004c0
W 0c 00000500
W 0d 00000540
W 0e 00000580
W 00 95979612
W 01 00921613
W 10 00000005
R 10 00000005
W 10 00000004
R 10 00000005
C mml_shr_u_rd 0 0 1000 0 0
C mml_shr_u_wr 0 1 1000 1 0
C mml_shr_m_wr 3 1 1000 0 0
C mml_shr_m_ex 3 2 1000 1 0
C mml_lx_u_ex 0 2 1100 0 1
C mml_lx_u_rd 0 0 1100 1 1
C mml_lx_m_rd 3 0 1100 0 1
C mml_lx_m_wr 3 1 1100 1 1
C mml_rwx_u_rd 0 0 1200 0 2
C mml_rwx_m_wr 3 1 1200 1 2
C mml_rwx_u_ex 0 2 1200 1 2
C mml_monly_m_ex 3 2 1300 0 3
C mml_monly_u_ex 0 2 1300 1 3
C mml_su_u_wr 0 1 1400 0 4
C mml_su_s_rd 1 0 1400 0 4
C mml_su_m_rd 3 0 1400 1 4
C mml_shrw_u_wr 0 1 1500 0 5
C mml_shrw_u_ex 0 2 1500 1 5
C mml_shx_m_ex 3 2 1600 0 6
C mml_shx_m_rd 3 0 1600 1 6
C mml_m_nomatch 3 0 8000 0 0
# Back-to-back burst
P pipe_a 0 0 1000 0 0
P pipe_b 0 1 1000 1 0
P pipe_c 3 2 1300 0 3
P pipe_d 0 2 1300 1 3
P pipe_e 0 0 8000 1 0
G

//--- src.f
+incdir+hw
hw/pmp_pkg.sv
hw/pmp_csr_regs.sv
hw/pmp_region_match.sv
hw/pmp_perm_check.sv
hw/pmp_fault_resolve.sv
hw/pmp_top.sv
bench/pmp_tb.sv
